/* lsu_pkg.sv */
// Shared sizes, access-size codes and types for the load/store unit
// Referenced by scoped name from every RTL file of the unit

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN   = 32;
  // One enable per byte lane
  localparam int unsigned BE_W   = 4;
  // Byte offset inside a word
  localparam int unsigned OFS_W  = 2;
  localparam int unsigned SIZE_W = 2;

  // Access-size codes as seen on ex_size_i
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // Outstanding transactions
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CNT_W = 2;
  // Two bus transactions in flight at most
  localparam logic [CNT_W-1:0] DEPTH = 2'd2;

  // Bus word, decoded by byte for byte loads and by halfword for
  // halfword loads
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } lsu_word_u;

endpackage

/* lsu_ctrl.sv */
// Control of the load/store unit: split detection, outstanding counter,
// execute and bus handshakes, write-back strobe, busy and interruptible
`timescale 1ns/10ps

module lsu_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  // Execute side
  input  logic                        ex_valid_i,
  input  logic [lsu_pkg::SIZE_W-1:0]  ex_size_i,
  input  logic [lsu_pkg::OFS_W-1:0]   ex_addr_ofs_i,
  output logic                        ex_ready_o,
  output logic                        split_o,
  // Bus side
  output logic                        data_req_o,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  // Datapath control
  input  logic                        last_q_i,
  output logic                        phase_update_o,
  output logic                        split_q_o,
  // Status
  output logic                        wb_valid_o,
  output logic                        busy_o,
  output logic                        interruptible_o
);

  // Outstanding transaction counter
  logic [lsu_pkg::CNT_W-1:0] cnt_q;
  logic [lsu_pkg::CNT_W-1:0] cnt_d;
  logic                      count_up;
  logic                      count_down;

  // Second address phase of a split access in progress
  logic                      split_q;
  // Request raised in an earlier cycle and still not granted
  logic                      req_wait_q;
  logic                      granted;

  //////////////////////////////////////////////////////////////////////
  // Split detection
  //////////////////////////////////////////////////////////////////////

  // Only a first phase can split
  // Words off a word boundary and halfwords at offset 3 cross a word
  always_comb begin
    split_o = 1'b0;
    if (ex_valid_i && !split_q) begin
      if (ex_size_i == lsu_pkg::SIZE_WORD) begin
        split_o = (ex_addr_ofs_i != 2'b00);
      end else if (ex_size_i == lsu_pkg::SIZE_HALF) begin
        split_o = (ex_addr_ofs_i == 2'b11);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  // Request only while a slot is free
  assign data_req_o = ex_valid_i && (cnt_q < lsu_pkg::DEPTH);
  assign granted    = data_req_o && data_gnt_i;

  // One address phase finished, datapath registers move on
  assign phase_update_o = granted;

  // Execute released only after the last address phase
  assign ex_ready_o = granted && !split_o;

  // Write-back on the response of the last part only
  assign wb_valid_o = data_rvalid_i && last_q_i;

  assign split_q_o = split_q;

  // Cleared when execute drops the access, so the next first phase
  // never starts with a stale split flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!ex_valid_i) begin
      split_q <= 1'b0;
    end else if (phase_update_o) begin
      split_q <= split_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  // Up on grant, down on response, both may happen together
  assign count_up   = granted;
  assign count_down = data_rvalid_i;

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////

  // A raised request may not be withdrawn, so a request that already
  // waited a cycle blocks interrupts until its grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_wait_q <= 1'b0;
    end else if (phase_update_o) begin
      req_wait_q <= 1'b0;
    end else if (data_req_o) begin
      req_wait_q <= 1'b1;
    end
  end

  // Interruptible only with no bus activity committed
  assign interruptible_o = !req_wait_q && (cnt_q == '0);

  // Busy with a request on the bus or responses still due
  assign busy_o = data_req_o || req_wait_q || (cnt_q != '0);

endmodule

/* lsu_req_align.sv */
// Address phase datapath: address sum, byte enables and write-data lanes,
// plus the per-phase info registers consumed at response time
`timescale 1ns/10ps

module lsu_req_align (
  input  logic                        clk,
  input  logic                        rst_n,
  // Execute side
  input  logic                        ex_we_i,
  input  logic [lsu_pkg::SIZE_W-1:0]  ex_size_i,
  input  logic                        ex_sext_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_op_a_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_op_b_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_wdata_i,
  // From control
  input  logic                        split_q_i,
  input  logic                        phase_update_i,
  input  logic                        split_i,
  output logic [lsu_pkg::OFS_W-1:0]   ex_addr_ofs_o,
  // Bus request
  output logic [lsu_pkg::XLEN-1:0]    data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::XLEN-1:0]    data_wdata_o,
  // Write-back info, one phase behind
  output logic [lsu_pkg::SIZE_W-1:0]  wb_size_o,
  output logic                        wb_sext_o,
  output logic                        wb_we_o,
  output logic [lsu_pkg::OFS_W-1:0]   wb_ofs_o,
  output logic                        last_q_o
);

  logic [lsu_pkg::XLEN-1:0]  addr;
  logic [lsu_pkg::OFS_W-1:0] ofs;

  // Effective address
  assign addr          = ex_op_a_i + ex_op_b_i;
  assign ofs           = addr[1:0];
  assign ex_addr_ofs_o = ofs;

  // Second phase goes to the next word, starting at lane 0
  assign data_addr_o = split_q_i ? ({addr[31:2], 2'b00} + 32'd4) : addr;
  assign data_we_o   = ex_we_i;

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (ex_size_i == lsu_pkg::SIZE_BYTE) begin
      data_be_o = 4'b0001 << ofs;
    end else if (ex_size_i == lsu_pkg::SIZE_HALF) begin
      if (split_q_i) begin
        // Upper byte of a halfword at offset 3
        data_be_o = 4'b0001;
      end else begin
        // Offset 3 keeps only lane 3 here
        data_be_o = 4'b0011 << ofs;
      end
    end else begin
      if (split_q_i) begin
        // Remaining low lanes of the next word
        data_be_o = ~(4'b1111 << ofs);
      end else begin
        data_be_o = 4'b1111 << ofs;
      end
    end
  end

  // Rotate write data so byte 0 lands on the lane of the offset
  // Bytes that wrapped around are used by the second phase
  always_comb begin
    case (ofs)
      2'b00: data_wdata_o = ex_wdata_i;
      2'b01: data_wdata_o = {ex_wdata_i[23:0], ex_wdata_i[31:24]};
      2'b10: data_wdata_o = {ex_wdata_i[15:0], ex_wdata_i[31:16]};
      default: data_wdata_o = {ex_wdata_i[7:0], ex_wdata_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Response-time info
  //////////////////////////////////////////////////////////////////////

  // Captured on each granted phase; first part of a split is not last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_size_o <= lsu_pkg::SIZE_BYTE;
      wb_sext_o <= 1'b0;
      wb_we_o   <= 1'b0;
      wb_ofs_o  <= '0;
      last_q_o  <= 1'b0;
    end else if (phase_update_i) begin
      wb_size_o <= ex_size_i;
      wb_sext_o <= ex_sext_i;
      wb_we_o   <= ex_we_i;
      wb_ofs_o  <= ofs;
      last_q_o  <= !split_i;
    end
  end

endmodule

/* lsu_rdata_align.sv */
// Response datapath: lane selection, split reassembly and sign extension
// Result is combinational to wb_rdata_o in the response cycle
`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic                        clk,
  input  logic                        rst_n,
  // Bus response
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]    data_rdata_i,
  input  logic                        data_err_i,
  // Info of the phase being answered
  input  logic [lsu_pkg::SIZE_W-1:0]  wb_size_i,
  input  logic                        wb_sext_i,
  input  logic                        wb_we_i,
  input  logic [lsu_pkg::OFS_W-1:0]   wb_ofs_i,
  input  logic                        last_q_i,
  // Write-back
  output logic [lsu_pkg::XLEN-1:0]    wb_rdata_o,
  output logic                        wb_err_o
);

  // Current bus word and the word held from the previous response
  lsu_pkg::lsu_word_u       rword;
  lsu_pkg::lsu_word_u       held_q;

  logic [7:0]               byte_sel;
  logic [15:0]              half_sel;
  logic [lsu_pkg::XLEN-1:0] word_sel;
  logic [lsu_pkg::XLEN-1:0] rdata_ext;
  // Error seen on the first part of a split access
  logic                     err_q;

  assign rword = data_rdata_i;

  //////////////////////////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////////////////////////

  assign byte_sel = rword.bytes[wb_ofs_i];

  // Offset 3 takes its low byte from the held first half
  always_comb begin
    case (wb_ofs_i)
      2'b00: half_sel = rword.halves[0];
      2'b01: half_sel = {rword.bytes[2], rword.bytes[1]};
      2'b10: half_sel = rword.halves[1];
      default: half_sel = {rword.bytes[0], held_q.bytes[3]};
    endcase
  end

  // Split words: upper lanes of the held word, then low lanes of this one
  always_comb begin
    case (wb_ofs_i)
      2'b00: word_sel = rword;
      2'b01: word_sel = {rword.bytes[0], held_q.bytes[3], held_q.bytes[2],
                         held_q.bytes[1]};
      2'b10: word_sel = {rword.halves[0], held_q.halves[1]};
      default: word_sel = {rword.bytes[2], rword.bytes[1], rword.bytes[0],
                           held_q.bytes[3]};
    endcase
  end

  // Sign or zero extension by size
  always_comb begin
    if (wb_size_i == lsu_pkg::SIZE_BYTE) begin
      rdata_ext = {{24{wb_sext_i & byte_sel[7]}}, byte_sel};
    end else if (wb_size_i == lsu_pkg::SIZE_HALF) begin
      rdata_ext = {{16{wb_sext_i & half_sel[15]}}, half_sel};
    end else begin
      rdata_ext = word_sel;
    end
  end

  assign wb_rdata_o = rdata_ext;

  //////////////////////////////////////////////////////////////////////
  // Held word
  //////////////////////////////////////////////////////////////////////

  // First part keeps the raw word for reassembly
  // Last part keeps the extended result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_q <= '0;
    end else if (data_rvalid_i && !wb_we_i) begin
      if (last_q_i) begin
        held_q <= rdata_ext;
      end else begin
        held_q <= rword;
      end
    end
  end

  // First-part error carried to the single write-back of the access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (data_rvalid_i) begin
      err_q <= last_q_i ? 1'b0 : data_err_i;
    end
  end

  assign wb_err_o = data_err_i || err_q;

endmodule

/* lsu_top.sv */
// Load/store unit top level
// Connects the control block to the request and response datapaths
`timescale 1ns/10ps

module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // Execute side
  input  logic                        ex_valid_i,
  input  logic                        ex_we_i,
  input  logic [lsu_pkg::SIZE_W-1:0]  ex_size_i,
  input  logic                        ex_sext_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_op_a_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_op_b_i,
  input  logic [lsu_pkg::XLEN-1:0]    ex_wdata_i,
  output logic                        ex_ready_o,
  output logic                        split_o,
  // Bus side
  output logic                        data_req_o,
  output logic [lsu_pkg::XLEN-1:0]    data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BE_W-1:0]    data_be_o,
  output logic [lsu_pkg::XLEN-1:0]    data_wdata_o,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]    data_rdata_i,
  input  logic                        data_err_i,
  // Write-back side
  output logic                        wb_valid_o,
  output logic [lsu_pkg::XLEN-1:0]    wb_rdata_o,
  output logic                        wb_err_o,
  // Status
  output logic                        busy_o,
  output logic                        interruptible_o
);

  logic                       split_q;
  logic                       phase_update;
  logic [lsu_pkg::OFS_W-1:0]  ex_addr_ofs;
  logic [lsu_pkg::SIZE_W-1:0] wb_size;
  logic                       wb_sext;
  logic                       wb_we;
  logic [lsu_pkg::OFS_W-1:0]  wb_ofs;
  logic                       last_q;

  lsu_ctrl ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_i),
    .ex_size_i       (ex_size_i),
    .ex_addr_ofs_i   (ex_addr_ofs),
    .ex_ready_o      (ex_ready_o),
    .split_o         (split_o),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .last_q_i        (last_q),
    .phase_update_o  (phase_update),
    .split_q_o       (split_q),
    .wb_valid_o      (wb_valid_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  lsu_req_align req_align_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_we_i        (ex_we_i),
    .ex_size_i      (ex_size_i),
    .ex_sext_i      (ex_sext_i),
    .ex_op_a_i      (ex_op_a_i),
    .ex_op_b_i      (ex_op_b_i),
    .ex_wdata_i     (ex_wdata_i),
    .split_q_i      (split_q),
    .phase_update_i (phase_update),
    .split_i        (split_o),
    .ex_addr_ofs_o  (ex_addr_ofs),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .wb_size_o      (wb_size),
    .wb_sext_o      (wb_sext),
    .wb_we_o        (wb_we),
    .wb_ofs_o       (wb_ofs),
    .last_q_o       (last_q)
  );

  lsu_rdata_align rdata_align_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .wb_size_i     (wb_size),
    .wb_sext_i     (wb_sext),
    .wb_we_i       (wb_we),
    .wb_ofs_i      (wb_ofs),
    .last_q_i      (last_q),
    .wb_rdata_o    (wb_rdata_o),
    .wb_err_o      (wb_err_o)
  );

endmodule

/* lsu_checker.sv */
// Bus and handshake rules of the load/store unit, checked as assertions
// Bound to lsu_top from the testbench build
`timescale 1ns/10ps

module lsu_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     ex_ready_o,
  input logic                     split_o,
  input logic                     data_req_o,
  input logic [lsu_pkg::XLEN-1:0] data_addr_o,
  input logic                     data_we_o,
  input logic [lsu_pkg::BE_W-1:0] data_be_o,
  input logic [lsu_pkg::XLEN-1:0] data_wdata_o,
  input logic                     data_gnt_i,
  input logic                     data_rvalid_i,
  input logic                     wb_valid_o
);

  // Accepted requests still waiting for a response
  logic [2:0] out_q;
  // Accesses released by execute and still owed a write-back
  logic [2:0] acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q <= '0;
    end else begin
      out_q <= out_q + {2'b00, data_req_o && data_gnt_i} - {2'b00, data_rvalid_i};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + {2'b00, ex_ready_o} - {2'b00, wb_valid_o};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus rules
  //////////////////////////////////////////////////////////////////////

  // Raised request keeps its content until granted
  a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_be_o) && $stable(data_we_o) && $stable(data_wdata_o))
    else $error("bus request changed before its grant");

  a_depth : assert property (@(posedge clk) disable iff (!rst_n)
    out_q <= 3'd2)
    else $error("more than two bus transactions outstanding");

  // Response only for an accepted request
  a_rvalid_owed : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> out_q != 3'd0)
    else $error("bus response without an outstanding request");

  // Second part of a split goes to the following word
  a_split_next_word : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && data_gnt_i && split_o |=>
      data_req_o && (data_addr_o == (($past(data_addr_o) | 32'd3) + 32'd1)))
    else $error("second part of a split access not at the next word");

  //////////////////////////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////////////////////////

  // Write-back only for an access that execute already handed over
  a_wb_owed : assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o |-> acc_q != 3'd0)
    else $error("write-back without a pending access");

endmodule

bind lsu_top lsu_checker chk_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .ex_ready_o    (ex_ready_o),
  .split_o       (split_o),
  .data_req_o    (data_req_o),
  .data_addr_o   (data_addr_o),
  .data_we_o     (data_we_o),
  .data_be_o     (data_be_o),
  .data_wdata_o  (data_wdata_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .wb_valid_o    (wb_valid_o)
);

/* tb_lsu.sv */
// Testbench for lsu_top: bus memory model with random grant stalls,
// accesses and expected results read from lsu_testdata.txt
`timescale 1ns/10ps

module tb_lsu;

  // Eight columns per access in the data file
  localparam int COLS       = 8;
  localparam int MAX_ACCESS = 64;

  logic        clk;
  logic        rst_n;
  logic        ex_valid_i;
  logic        ex_we_i;
  logic [1:0]  ex_size_i;
  logic        ex_sext_i;
  logic [31:0] ex_op_a_i;
  logic [31:0] ex_op_b_i;
  logic [31:0] ex_wdata_i;
  logic        ex_ready_o;
  logic        split_o;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic [31:0] data_rdata_i;
  logic        data_err_i;
  logic        wb_valid_o;
  logic [31:0] wb_rdata_o;
  logic        wb_err_o;
  logic        busy_o;
  logic        interruptible_o;

  logic [31:0] td [0:COLS*MAX_ACCESS-1];
  logic [31:0] mem [0:63];
  logic [31:0] seed;
  logic        cur_err;
  logic [31:0] grant_addr_q[$];
  logic [3:0]  grant_be_q[$];
  logic        grant_split_q[$];
  int          n_access;
  int          errors;
  int          tests_failed;
  int          wb_count;
  int          outstanding;
  int          max_outstanding;

  lsu_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0000, seed[31:16]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Lanes over two words; upper nibble is the second word
  function automatic logic [3:0] expected_be(input logic [1:0] size,
                                             input logic [1:0] ofs,
                                             input bit second);
    logic [7:0] mask;
    case (size)
      2'd0:    mask = 8'b0000_0001;
      2'd1:    mask = 8'b0000_0011;
      default: mask = 8'b0000_1111;
    endcase
    mask = mask << ofs;
    return second ? mask[7:4] : mask[3:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////////////////////////

  // Grant stalls from the LCG, response one cycle after grant
  always @(posedge clk) begin
    logic [31:0] rnd;
    logic [5:0]  idx;
    rnd = next_rand();
    idx = data_addr_o[7:2];
    if (!rst_n) begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_err_i    <= 1'b0;
    end else begin
      data_gnt_i <= (rnd[1:0] != 2'b00);
      if (data_req_o && data_gnt_i) begin
        grant_addr_q.push_back(data_addr_o);
        grant_be_q.push_back(data_be_o);
        grant_split_q.push_back(split_o);
        data_rvalid_i <= 1'b1;
        data_err_i    <= cur_err;
        data_rdata_i  <= mem[idx];
        if (data_we_o) begin
          for (int k = 0; k < 4; k++) begin
            if (data_be_o[k]) begin
              mem[idx][k*8 +: 8] = data_wdata_o[k*8 +: 8];
            end
          end
        end
      end else begin
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
      end
    end
  end

  // Outstanding depth and write-back pulses
  always @(posedge clk) begin
    if (rst_n) begin
      outstanding = outstanding + int'(data_req_o && data_gnt_i) - int'(data_rvalid_i);
      if (outstanding > max_outstanding) begin
        max_outstanding = outstanding;
      end
      if (wb_valid_o) begin
        wb_count++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // One access
  //////////////////////////////////////////////////////////////////////

  task automatic run_access(input int idx);
    logic [31:0] op;
    logic [31:0] size;
    logic [31:0] addr;
    logic [31:0] exp_rd;
    logic [31:0] err;
    logic [31:0] got_rd;
    logic        got_err;
    int          phases;
    int          errs0;
    op     = td[idx*COLS];
    size   = td[idx*COLS+1];
    addr   = td[idx*COLS+3] + td[idx*COLS+4];
    exp_rd = td[idx*COLS+6];
    err    = td[idx*COLS+7];
    errs0  = errors;
    phases = (expected_be(size[1:0], addr[1:0], 1'b1) != 4'b0000) ? 2 : 1;
    grant_addr_q.delete();
    grant_be_q.delete();
    grant_split_q.delete();
    cur_err = err[0];
    ex_valid_i <= 1'b1;
    ex_we_i    <= (op == 32'd2);
    ex_size_i  <= size[1:0];
    ex_sext_i  <= td[idx*COLS+2][0];
    ex_op_a_i  <= td[idx*COLS+3];
    ex_op_b_i  <= td[idx*COLS+4];
    ex_wdata_i <= td[idx*COLS+5];
    // Handshake seen on the edge where ex_ready_o was high
    do @(posedge clk); while (!ex_ready_o);
    // A request is on the bus at the handshake
    check_value("busy_o", {31'b0, busy_o}, 32'd1);
    ex_valid_i <= 1'b0;
    do @(posedge clk); while (!wb_valid_o);
    got_rd  = wb_rdata_o;
    got_err = wb_err_o;
    if (op == 32'd1) begin
      check_value("wb_rdata_o", got_rd, exp_rd);
    end
    check_value("wb_err_o", {31'b0, got_err}, {31'b0, err[0]});
    if (grant_addr_q.size() != phases) begin
      $display("Access %0d issued %0d bus requests instead of %0d", idx,
               grant_addr_q.size(), phases);
      errors++;
    end else begin
      check_value("data_addr_o", grant_addr_q[0], addr);
      check_value("data_be_o", {28'b0, grant_be_q[0]},
                  {28'b0, expected_be(size[1:0], addr[1:0], 1'b0)});
      check_value("split_o", {31'b0, grant_split_q[0]}, {31'b0, phases == 2});
      if (phases == 2) begin
        // Next word boundary above the first byte
        check_value("data_addr_o", grant_addr_q[1], (addr | 32'd3) + 32'd1);
        check_value("data_be_o", {28'b0, grant_be_q[1]},
                    {28'b0, expected_be(size[1:0], addr[1:0], 1'b1)});
        check_value("split_o", {31'b0, grant_split_q[1]}, 32'd0);
      end
    end
    if (errors != errs0) begin
      tests_failed++;
    end
    $display("test %0d %s size %0d addr %h parts %0d: %s", idx,
             (op == 32'd2) ? "store" : "load", size, addr, phases,
             (errors == errs0) ? "ok" : "wrong");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 32'h2cbc;
    errors          = 0;
    tests_failed    = 0;
    wb_count        = 0;
    outstanding     = 0;
    max_outstanding = 0;
    n_access        = 0;
    cur_err         = 1'b0;
    rst_n           = 1'b0;
    ex_valid_i      = 1'b0;
    ex_we_i         = 1'b0;
    ex_size_i       = 2'd0;
    ex_sext_i       = 1'b0;
    ex_op_a_i       = '0;
    ex_op_b_i       = '0;
    ex_wdata_i      = '0;
    data_gnt_i      = 1'b0;
    data_rvalid_i   = 1'b0;
    data_rdata_i    = '0;
    data_err_i      = 1'b0;
    for (int i = 0; i < COLS*MAX_ACCESS; i++) begin
      td[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    end
    $readmemh("lsu_testdata.txt", td);
    // Op column is never zero on a real line
    while (n_access < MAX_ACCESS && td[n_access*COLS] != 32'd0) begin
      n_access++;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("data_req_o", {31'b0, data_req_o}, 32'd0);
    check_value("ex_ready_o", {31'b0, ex_ready_o}, 32'd0);
    check_value("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
    check_value("split_o", {31'b0, split_o}, 32'd0);
    check_value("busy_o", {31'b0, busy_o}, 32'd0);
    check_value("interruptible_o", {31'b0, interruptible_o}, 32'd1);
    if (n_access == 0) begin
      $display("No accesses were read from lsu_testdata.txt");
      errors++;
    end
    for (int i = 0; i < n_access; i++) begin
      run_access(i);
    end
    repeat (4) @(posedge clk);
    check_value("wb_valid count", wb_count, n_access);
    // Idle again once every response has returned
    check_value("busy_o", {31'b0, busy_o}, 32'd0);
    check_value("interruptible_o", {31'b0, interruptible_o}, 32'd1);
    if (max_outstanding > 2) begin
      $display("More than two bus transactions were outstanding");
      errors++;
    end
    $display("accesses %0d, failed %0d, errors %0d", n_access, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog sized by the number of accesses
  initial begin
    wait (n_access > 0);
    #(n_access * 200);
    $display("Watchdog expired, an access never completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* lsu_testdata.txt */
// op(1 load, 2 store) size(0 byte, 1 half, 2 word) sext op_a op_b wdata
// expected read data, bus error on the response
2 2 0 00000018 00000008 80f17f02 00000000 0
1 2 0 00000020 00000000 00000000 80f17f02 0
1 0 1 00000020 00000000 00000000 00000002 0
1 0 1 00000020 00000001 00000000 0000007f 0
1 0 1 00000021 00000001 00000000 fffffff1 0
1 0 1 00000023 00000000 00000000 ffffff80 0
1 0 0 00000022 00000000 00000000 000000f1 0
1 0 0 00000020 00000003 00000000 00000080 0
1 1 1 00000020 00000000 00000000 00007f02 0
1 1 1 00000020 00000001 00000000 fffff17f 0
1 1 1 00000020 00000002 00000000 ffff80f1 0
1 1 0 00000020 00000002 00000000 000080f1 0
2 0 0 00000024 00000000 000000c5 00000000 0
1 1 1 00000020 00000003 00000000 ffffc580 0
1 1 0 00000023 00000000 00000000 0000c580 0
2 2 0 00000030 00000001 cafef00d 00000000 0
1 2 0 00000031 00000000 00000000 cafef00d 0
1 0 0 00000031 00000000 00000000 0000000d 0
1 0 1 00000034 00000000 00000000 ffffffca 0
2 2 0 00000040 00000002 12345678 00000000 0
1 2 0 00000042 00000000 00000000 12345678 0
1 1 0 00000042 00000000 00000000 00005678 0
1 1 1 00000044 00000000 00000000 00001234 0
2 2 0 00000050 00000003 0badc0de 00000000 0
1 2 0 00000053 00000000 00000000 0badc0de 0
1 0 0 00000056 00000000 00000000 0000000b 0
2 1 0 00000060 00000003 0000beef 00000000 0
1 1 0 00000063 00000000 00000000 0000beef 0
1 0 1 00000064 00000000 00000000 ffffffbe 0
2 1 0 00000061 00000000 00001357 00000000 0
1 1 1 00000061 00000000 00000000 00001357 0
1 2 0 00000020 00000000 00000000 80f17f02 1
1 2 0 00000031 00000000 00000000 cafef00d 1
2 2 0 00000070 00000000 00c0ffee 00000000 1
1 2 0 00000070 00000000 00000000 00c0ffee 0

/* project.f */
lsu_pkg.sv
lsu_ctrl.sv
lsu_req_align.sv
lsu_rdata_align.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_lsu -f project.f -o tb_lsu_sim \
  && ./obj_dir/tb_lsu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "result: passed" \
  || { echo "result: failed"; exit 1; }
